//--- hw/lsu_params.svh
// Data width, RAM depth, wait-state count and register number width macros

`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Register and bus data width
`define LSU_XLEN 64

// Number of doublewords in the data RAM
`define LSU_RAM_WORDS 256

// Cycles from a seen strobe to its completion pulse
`define LSU_WAIT_CYCLES 2

// Register number width
`define LSU_RN_BITS 6

`endif

//--- hw/lsu_pkg.sv
// Dispatch unit codes, access width codes and the RAM word union

`include "lsu_params.svh"

package lsu_pkg;

    ////////////////////////////////////////
    // Dispatch unit codes
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        UNIT_LOAD  = 3'h4,  // Zero-extending load
        UNIT_SLOAD = 3'h5,  // Sign-extending load, LUI when op is 0
        UNIT_STORE = 3'h6
    } unit_code_t;

    ////////////////////////////////////////
    // Access widths, taken from the op field
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        WIDTH8  = 2'h0,
        WIDTH16 = 2'h1,
        WIDTH32 = 2'h2,
        WIDTH64 = 2'h3
    } mem_width_t;

    // One RAM doubleword, byte 0 is the most significant lane
    typedef union packed {
        logic [`LSU_XLEN-1:0] d;
        logic [0:7][7:0]      b;
    } ram_word_u;

endpackage

//--- hw/dmem_if.sv
// Strobe-based data memory bus with master and slave modports

`include "lsu_params.svh"

interface dmem_if import lsu_pkg::*; ();

    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] dout;  // Store data
    logic [`LSU_XLEN-1:0] din;   // Read data, left-aligned
    mem_width_t           width;
    logic                 rstrobe;
    logic                 wstrobe;
    logic                 cycle_complete;

    // Execute unit side
    modport master (
        output addr, dout, width, rstrobe, wstrobe,
        input  din, cycle_complete
    );

    // RAM side
    modport slave (
        input  addr, dout, width, rstrobe, wstrobe,
        output din, cycle_complete
    );

endinterface

//--- hw/mem_exec_unit.sv
// Load, store and LUI execute unit with its memory access FSM

`include "lsu_params.svh"

module mem_exec_unit import lsu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,

    // Dispatch side
    input  logic [`LSU_XLEN-1:0]    base,
    input  logic [`LSU_XLEN-1:0]    data,
    input  logic [31:0]             offset,
    input  logic                    ex_enable,
    input  logic [`LSU_RN_BITS-1:0] rd_in_rn,
    input  logic [2:0]              unit,
    input  logic [1:0]              op,
    output logic                    ex_busy,

    // Commit side
    output logic [`LSU_XLEN-1:0]    out,
    output logic [`LSU_RN_BITS-1:0] rd_out_rn,
    output logic                    valid,
    input  logic                    stall,

    dmem_if.master                  bus
);

    localparam logic [1:0] ST_IDLE       = 2'h0;
    localparam logic [1:0] ST_READ_WAIT  = 2'h1;
    localparam logic [1:0] ST_WRITE_WAIT = 2'h2;

    logic [1:0]              state;
    logic [`LSU_RN_BITS-1:0] rd_reg;
    unit_code_t              unit_reg;
    logic [1:0]              op_reg;

    logic                    is_load;
    logic                    is_store;
    logic                    is_lui;
    logic                    sign_ext;
    logic [3:0]              field_bytes;
    logic [6:0]              field_shamt;
    logic [`LSU_XLEN-1:0]    load_result;

    ////////////////////////////////////////
    // Operation capture
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_reg   <= '0;
            unit_reg <= UNIT_LOAD;
            op_reg   <= '0;
        end else if (ex_enable) begin
            rd_reg   <= rd_in_rn;
            unit_reg <= unit_code_t'(unit);
            op_reg   <= op;
        end
    end

    // Decode straight from dispatch, valid only with ex_enable
    assign is_load  = (unit == UNIT_LOAD) || (unit == UNIT_SLOAD && op != 2'h0);
    assign is_store = (unit == UNIT_STORE);
    assign is_lui   = (unit == UNIT_SLOAD) && (op == 2'h0);

    assign sign_ext  = (unit_reg == UNIT_SLOAD);  // LUI never reaches a load wait
    assign bus.width = mem_width_t'(op_reg);

    ////////////////////////////////////////
    // Load field extraction
    ////////////////////////////////////////

    // Narrow field sits in the top bytes of din
    assign field_bytes = 4'd1 << op_reg;
    assign field_shamt = 7'(`LSU_XLEN) - {field_bytes, 3'b000};

    always_comb begin
        if (sign_ext) begin
            load_result = $signed(bus.din) >>> field_shamt;
        end else begin
            load_result = bus.din >> field_shamt;
        end
    end

    assign ex_busy = ex_enable || stall || (state != ST_IDLE && !bus.cycle_complete);

    ////////////////////////////////////////
    // Access FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            out         <= '0;
            valid       <= 1'b0;
            rd_out_rn   <= '0;
            bus.rstrobe <= 1'b0;
            bus.wstrobe <= 1'b0;
        end else begin
            bus.rstrobe <= 1'b0;  // Strobes last one cycle
            bus.wstrobe <= 1'b0;
            valid       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    rd_out_rn <= '0;
                    if (ex_enable) begin
                        if (is_load) begin
                            bus.rstrobe <= 1'b1;
                            state       <= ST_READ_WAIT;
                        end else if (is_store) begin
                            bus.wstrobe <= 1'b1;
                            state       <= ST_WRITE_WAIT;
                        end else if (is_lui) begin
                            out       <= {offset, {(`LSU_XLEN-32){1'b0}}};
                            valid     <= 1'b1;
                            rd_out_rn <= rd_in_rn;
                        end
                    end
                end
                ST_READ_WAIT: begin
                    if (bus.cycle_complete) begin
                        out       <= load_result;
                        valid     <= 1'b1;
                        rd_out_rn <= rd_reg;
                        state     <= ST_IDLE;
                    end
                end
                ST_WRITE_WAIT: begin
                    if (bus.cycle_complete) begin
                        valid     <= 1'b1;
                        rd_out_rn <= '0;  // Stores write no register
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address and store data, held until the next access
    always_ff @(posedge clk) begin
        if (ex_enable && (is_load || is_store)) begin
            bus.addr <= base + `LSU_XLEN'(offset);
            bus.dout <= data;
        end
    end

endmodule

//--- hw/data_ram.sv
// Byte-lane data RAM with fixed wait states and left-aligned narrow reads

`include "lsu_params.svh"

module data_ram import lsu_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    dmem_if.slave  bus
);

    localparam int IDX_BITS = $clog2(`LSU_RAM_WORDS);
    localparam int CNT_BITS = $clog2(`LSU_WAIT_CYCLES + 1);

    ram_word_u            mem [`LSU_RAM_WORDS];

    logic [CNT_BITS-1:0]  wait_cnt;
    logic                 rd_pend;    // Access in flight is a read
    logic [IDX_BITS-1:0]  word_idx;
    logic [2:0]           byte_off;
    logic [3:0]           nbytes;
    logic [6:0]           fill_shamt;
    logic [`LSU_XLEN-1:0] top_mask;   // Ones over the top nbytes lanes
    logic [`LSU_XLEN-1:0] rd_word;
    ram_word_u            wr_word;
    logic [0:7]           byte_en;

    assign word_idx   = bus.addr[3 +: IDX_BITS];
    assign byte_off   = bus.addr[2:0];
    assign nbytes     = 4'd1 << bus.width;
    assign fill_shamt = 7'(`LSU_XLEN) - {nbytes, 3'b000};
    assign top_mask   = {`LSU_XLEN{1'b1}} << fill_shamt;

    ////////////////////////////////////////
    // Wait-state counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
            rd_pend  <= 1'b0;
        end else if (bus.rstrobe || bus.wstrobe) begin
            wait_cnt <= CNT_BITS'(`LSU_WAIT_CYCLES);
            rd_pend  <= bus.rstrobe;
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    assign bus.cycle_complete = (wait_cnt == CNT_BITS'(1));

    ////////////////////////////////////////
    // Read and write paths
    ////////////////////////////////////////

    // Selected lanes moved to the top, zeros below
    assign rd_word = (mem[word_idx].d << {byte_off, 3'b000}) & top_mask;
    assign bus.din = (bus.cycle_complete && rd_pend) ? rd_word : '0;

    // Low store bytes lifted to the top, then slid down to the target lane
    assign wr_word.d = (bus.dout << fill_shamt) >> {byte_off, 3'b000};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            byte_en[i] = (i >= byte_off) && (i < byte_off + nbytes);
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cycle_complete && !rd_pend) begin
            for (int i = 0; i < 8; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx].b[i] <= wr_word.b[i];
                end
            end
        end
    end

endmodule

//--- hw/lsu_top.sv
// Load/store slice top level, execute unit joined to the data RAM

`include "lsu_params.svh"

module lsu_top (
    input  logic                    clk,
    input  logic                    rst_n,

    // Dispatch
    input  logic [`LSU_XLEN-1:0]    base,
    input  logic [`LSU_XLEN-1:0]    data,
    input  logic [31:0]             offset,
    input  logic                    ex_enable,
    input  logic [`LSU_RN_BITS-1:0] rd_in_rn,
    input  logic [2:0]              unit,
    input  logic [1:0]              op,
    output logic                    ex_busy,

    // Commit
    input  logic                    stall,
    output logic [`LSU_XLEN-1:0]    out,
    output logic [`LSU_RN_BITS-1:0] rd_out_rn,
    output logic                    valid
);

    ////////////////////////////////////////
    // Internal data memory bus
    ////////////////////////////////////////

    dmem_if dmem ();

    mem_exec_unit u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .base      (base),
        .data      (data),
        .offset    (offset),
        .ex_enable (ex_enable),
        .rd_in_rn  (rd_in_rn),
        .unit      (unit),
        .op        (op),
        .ex_busy   (ex_busy),
        .out       (out),
        .rd_out_rn (rd_out_rn),
        .valid     (valid),
        .stall     (stall),
        .bus       (dmem.master)
    );

    data_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (dmem.slave)
    );

endmodule

//--- tests/lsu_checker.sv
// Bound checker with a shadow byte memory and commit assertions for lsu_top

`include "lsu_params.svh"

module lsu_checker import lsu_pkg::*; (
    input logic                    clk, rst_n, ex_enable, stall, ex_busy, valid,
    input logic [`LSU_XLEN-1:0]    base, data, out,
    input logic [31:0]             offset,
    input logic [`LSU_RN_BITS-1:0] rd_in_rn, rd_out_rn,
    input logic [2:0]              unit,
    input logic [1:0]              op
);

    localparam int ABITS = $clog2(`LSU_RAM_WORDS * 8);

    logic [7:0]              shadow [`LSU_RAM_WORDS * 8];  // One entry per byte address
    int                      fail_count = 0;
    int                      busy_cnt;   // Cycles an access still holds ex_busy
    logic [`LSU_XLEN-1:0]    exp_out;
    logic [`LSU_RN_BITS-1:0] exp_rd;
    logic                    exp_store;
    logic [ABITS-1:0]        st_addr;
    logic [`LSU_XLEN-1:0]    st_data;
    logic [1:0]              st_w;
    logic                    is_lui;
    logic                    is_mem;
    logic [`LSU_XLEN-1:0]    acc_addr;

    assign is_lui   = (unit == UNIT_SLOAD) && (op == 2'd0);
    assign is_mem   = (unit == UNIT_LOAD) || (unit == UNIT_STORE)
                   || (unit == UNIT_SLOAD && op != 2'd0);
    assign acc_addr = base + {32'h0, offset};

    // Lowest address is the most significant byte of the field
    function automatic logic [`LSU_XLEN-1:0] load_value(input logic [ABITS-1:0] a,
                                                        input logic [1:0] w, input logic sgn);
        logic [`LSU_XLEN-1:0] v;
        int                   n;
        n = 1 << w;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[`LSU_XLEN-9:0], shadow[a + i]};
        end
        if (sgn && v[8*n-1]) begin
            v = v | ({`LSU_XLEN{1'b1}} << (8 * n));
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // Expected result tracking
    ////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_out   <= '0;
            exp_rd    <= '0;
            exp_store <= 1'b0;
            st_addr   <= '0;
            st_data   <= '0;
            st_w      <= '0;
            busy_cnt  <= 0;
        end else begin
            if (busy_cnt != 0) busy_cnt <= busy_cnt - 1;
            if (ex_enable) begin
                exp_store <= (unit == UNIT_STORE);
                exp_rd    <= (unit == UNIT_STORE) ? '0 : rd_in_rn;
                exp_out   <= is_lui ? {offset, {(`LSU_XLEN-32){1'b0}}}
                                    : load_value(acc_addr[ABITS-1:0], op, unit == UNIT_SLOAD);
                st_addr   <= acc_addr[ABITS-1:0];
                st_data   <= data;
                st_w      <= op;
                if (is_mem) busy_cnt <= `LSU_WAIT_CYCLES;
            end
        end
    end

    // Store commits land in the shadow memory
    always @(posedge clk) begin
        if (rst_n && valid && exp_store) begin
            for (int i = 0; i < (1 << st_w); i++) begin
                shadow[st_addr + i] <= st_data[8*((1 << st_w)-1-i) +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    a_reset: assert property (@(posedge clk)
            $rose(rst_n) |-> !valid && rd_out_rn == '0 && out == '0)
        else begin
            fail_count++;
            $error({"CHECK FAILED t=%0t valid/rd_out_rn/out after reset ",
                    "expected 0/0/0 got %b/%h/%h"},
                   $time, $sampled(valid), $sampled(rd_out_rn), $sampled(out));
        end

    a_lui_time: assert property (@(posedge clk) disable iff (!rst_n)
            ex_enable && is_lui |=> valid)
        else begin
            fail_count++;
            $error("LUI did not commit one cycle after dispatch at t=%0t", $time);
        end

    a_mem_time: assert property (@(posedge clk) disable iff (!rst_n)
            ex_enable && is_mem |-> ##(`LSU_WAIT_CYCLES + 2) valid)
        else begin
            fail_count++;
            $error("Load or store missed its commit cycle at t=%0t", $time);
        end

    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
            ex_enable || stall || busy_cnt != 0 |-> ex_busy)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t ex_busy expected 1 got %b", $time, $sampled(ex_busy));
        end

    a_pulse: assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid)
        else begin
            fail_count++;
            $error("valid stayed high for two cycles at t=%0t", $time);
        end

    a_out: assert property (@(posedge clk) disable iff (!rst_n)
            valid && !exp_store |-> out == exp_out)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t out expected %h got %h",
                   $time, $sampled(exp_out), $sampled(out));
        end

    a_rd: assert property (@(posedge clk) disable iff (!rst_n) valid |-> rd_out_rn == exp_rd)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t rd_out_rn expected %0d got %0d",
                   $time, $sampled(exp_rd), $sampled(rd_out_rn));
        end

endmodule

bind lsu_top lsu_checker u_check (.*);

//--- tests/lsu_tb.sv
// Testbench for lsu_top with clock, reset, LFSR dispatch stimulus and the closing report

`include "lsu_params.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int TIMEOUT = 64;
    localparam int ROUNDS  = 40;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [`LSU_XLEN-1:0]    base;
    logic [`LSU_XLEN-1:0]    data;
    logic [31:0]             offset;
    logic                    ex_enable;
    logic [`LSU_RN_BITS-1:0] rd_in_rn;
    logic [2:0]              unit;
    logic [1:0]              op;
    logic                    stall;
    logic                    ex_busy;
    logic [`LSU_XLEN-1:0]    out;
    logic [`LSU_RN_BITS-1:0] rd_out_rn;
    logic                    valid;

    logic [31:0] lfsr = 32'hd346_d355;
    int          timeouts = 0;

    always #4 clk = ~clk;

    lsu_top u_lsu_top (.*);

    ////////////////////////////////////////
    // Random bits and helpers
    ////////////////////////////////////////

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    // Byte offset rounded down to the access size
    function automatic logic [63:0] align(input logic [63:0] bo, input logic [1:0] w);
        return bo[2:0] & ~((64'd1 << w) - 64'd1);
    endfunction

    task automatic drive_stall();
        logic [63:0] r;
        take_bits(2, r);
        stall = (r[1:0] == 2'b00);  // About one cycle in four
    endtask

    // Waits for ex_busy low, pulses ex_enable, then waits for the commit
    task automatic dispatch(input logic [2:0] u, input logic [1:0] o, input logic [63:0] b,
                            input logic [63:0] d, input logic [31:0] off);
        logic [63:0] r;
        int          n;
        take_bits(6, r);
        n = 0;
        @(negedge clk);
        while (ex_busy && n < TIMEOUT) begin
            ex_enable = 1'b0;
            drive_stall();
            @(negedge clk);
            n++;
        end
        if (ex_busy) begin
            timeouts++;
            $display("Timeout at %0t: ex_busy never dropped, operation skipped", $time);
            return;
        end
        unit      = u;
        op        = o;
        base      = b;
        data      = d;
        offset    = off;
        rd_in_rn  = r[`LSU_RN_BITS-1:0];
        ex_enable = 1'b1;
        stall     = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            ex_enable = 1'b0;
            drive_stall();
            n++;
        end while (!valid && n < TIMEOUT);
        if (!valid) begin
            timeouts++;
            $display("Timeout at %0t: no commit pulse for the dispatched operation", $time);
        end
    endtask

    // Random split of an aligned address into base and offset
    task automatic mem_op(input logic [2:0] u, input logic [1:0] w, input logic [63:0] addr,
                          input logic [63:0] d);
        logic [63:0] r;
        take_bits(12, r);
        dispatch(u, w, addr - r, d, r[31:0]);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        logic [63:0] dw;
        logic [63:0] r;
        logic [63:0] bo;
        logic [1:0]  w;
        int          fails;
        rst_n     = 1'b0;
        base      = '0;
        data      = '0;
        offset    = '0;
        ex_enable = 1'b0;
        rd_in_rn  = '0;
        unit      = '0;
        op        = '0;
        stall     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int k = 0; k < ROUNDS; k++) begin
            take_bits(8, r);
            dw = {53'h0, r[7:0], 3'b000};
            take_bits(64, r);
            mem_op(UNIT_STORE, WIDTH64, dw, r);
            take_bits(3, r);
            if (r[0]) begin  // Now and then a narrow store into the same doubleword
                w = r[2:1];
                take_bits(3, bo);
                take_bits(64, r);
                mem_op(UNIT_STORE, w, dw + align(bo, w), r);
            end
            repeat (3) begin
                take_bits(3, r);
                w = r[1:0];
                take_bits(3, bo);
                if (r[2] && w == 2'd0) begin
                    w = 2'd1;  // op 0 on the signed unit means LUI
                end
                mem_op(r[2] ? UNIT_SLOAD : UNIT_LOAD, w, dw + align(bo, w), '0);
            end
            take_bits(32, r);
            take_bits(16, bo);
            dispatch(UNIT_SLOAD, 2'd0, bo, '0, r[31:0]);
        end

        repeat (4) @(negedge clk);
        fails = u_lsu_top.u_check.fail_count;
        $display("Closing counts: %0d assertion failures, %0d timeouts", fails, timeouts);
        if (fails == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/lsu_pkg.sv
hw/dmem_if.sv
hw/mem_exec_unit.sv
hw/data_ram.sv
hw/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = lsu_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = Finished with no errors
FAIL_MSG  = Finished with errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG) || ! grep -qx "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
